//--- rtl/cache_pkg.sv
// sizes are fixed here; 4 ways only (tree PLRU), word-aligned core addresses, 12-bit byte space
package cache_pkg;

  localparam int ADDR_BITS   = 12;  // byte address
  localparam int WORD_BITS   = 32;
  localparam int LINE_BYTES  = 16;
  localparam int NUM_WAYS    = 4;
  localparam int NUM_SETS    = 4;
  localparam int OFFSET_BITS = 4;   // log2(LINE_BYTES)
  localparam int SET_BITS    = 2;
  localparam int TAG_BITS    = 6;   // ADDR_BITS - SET_BITS - OFFSET_BITS
  localparam int LRU_BITS    = 3;   // tree nodes per set, NUM_WAYS - 1
  localparam int MEM_LATENCY = 3;   // cycles from accept to response

  localparam int WAY_BITS       = 2;
  localparam int WORDS_PER_LINE = LINE_BYTES * 8 / WORD_BITS;
  localparam int LINE_IDX_BITS  = ADDR_BITS - OFFSET_BITS;
  localparam int MEM_LINES      = 2 ** LINE_IDX_BITS;  // 256 lines behind the cache
  localparam int LAT_CNT_BITS   = $clog2(MEM_LATENCY);
  localparam logic [15:0] MEM_MARK = 16'hc0de;         // high half of every reset word

  typedef logic [LINE_BYTES*8-1:0] line_t;
  typedef logic [WORD_BITS-1:0]    word_t;
  typedef logic [ADDR_BITS-1:0]    addr_t;
  typedef logic [ADDR_BITS-3:0]    word_addr_t;  // byte address without the low two bits

  // byte address split, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [SET_BITS-1:0]    set;
    logic [OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLUSH = 2'd2
  } cache_op_e;

  typedef struct packed {
    cache_op_e op;
    addr_t     addr;   // low two bits ignored
    word_t     wdata;  // OP_WRITE only
  } core_req_t;

  typedef struct packed {
    word_t     rdata;  // zero unless OP_READ
    logic      hit;    // always zero for OP_FLUSH
    cache_op_e op;
  } core_resp_t;

  typedef struct packed {
    logic  we;
    addr_t addr;   // line address, offset bits zero
    line_t wline;
  } mem_req_t;

  typedef struct packed {
    line_t rdata;
  } mem_resp_t;

  // reset content of the lower level: mark on top, word address below
  function automatic word_t mem_init_word(input word_addr_t waddr);
    return {MEM_MARK, 16'(waddr)};
  endfunction

endpackage

//--- rtl/set_ram.sv
// async read of all ways of one set, rising-edge write per way; reset zeroes every entry
module set_ram #(
  parameter type payload_t = cache_pkg::tag_entry_t
) (
  input  logic                            clk_in,
  input  logic                            rst_N_in,
  input  logic [cache_pkg::SET_BITS-1:0]  set_idx,
  input  logic [cache_pkg::NUM_WAYS-1:0]  we,      // one strobe per way
  input  payload_t                        wdata,
  output payload_t                        rdata [cache_pkg::NUM_WAYS]
);
  import cache_pkg::*;

  payload_t mem [NUM_SETS][NUM_WAYS];  // [set][way]

  // whole set visible at once for the tag compare
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rdata[w] = mem[set_idx][w];
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          mem[s][w] <= payload_t'('0);  // tag entries come up invalid
        end
      end
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (we[w]) begin
          mem[set_idx][w] <= wdata;  // same data to every enabled way
        end
      end
    end
  end

endmodule

//--- rtl/plru_tree.sv
// 3-node tree per set, valid for exactly 4 ways; node 0 is the root, 1 covers ways 0/1, 2 ways 2/3
module plru_tree (
  input  logic                           clk_in,
  input  logic                           rst_N_in,
  input  logic [cache_pkg::SET_BITS-1:0] set_idx,
  input  logic                           touch,      // access to touch_way this cycle
  input  logic [cache_pkg::WAY_BITS-1:0] touch_way,
  output logic [cache_pkg::WAY_BITS-1:0] victim_way
);
  import cache_pkg::*;

  logic [LRU_BITS-1:0] node_q [NUM_SETS];

  // node bit 0 points left, 1 points right
  function automatic logic [WAY_BITS-1:0] pick_victim(input logic [LRU_BITS-1:0] node);
    logic half;
    half = node[0];                          // root picks the half
    return {half, half ? node[2] : node[1]};
  endfunction

  // every node on the way's path turns away from it
  function automatic logic [LRU_BITS-1:0] point_away(input logic [LRU_BITS-1:0] node,
                                                     input logic [WAY_BITS-1:0] way);
    logic [LRU_BITS-1:0] next;
    next    = node;
    next[0] = ~way[1];
    if (way[1]) begin
      next[2] = ~way[0];
    end else begin
      next[1] = ~way[0];
    end
    return next;
  endfunction

  assign victim_way = pick_victim(node_q[set_idx]);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        node_q[s] <= '0;  // all point at way 0
      end
    end else if (touch) begin
      node_q[set_idx] <= point_away(node_q[set_idx], touch_way);
    end
  end

  // an X way would corrupt the tree of the whole set
  a_touch_way_known : assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    touch |-> !$isunknown(touch_way)
  );

endmodule

//--- rtl/cache_ctrl.sv
// one request in flight; write-allocate, write-back, fills are clean; flush keeps the PLRU bits
module cache_ctrl (
  input  logic                            clk_in,
  input  logic                            rst_N_in,
  // core side
  input  logic                            req_valid,
  output logic                            req_ready,
  input  cache_pkg::core_req_t            req,
  output logic                            resp_valid,
  input  logic                            resp_ready,
  output cache_pkg::core_resp_t           resp,
  // arrays
  output logic [cache_pkg::SET_BITS-1:0]  ram_set,
  output logic [cache_pkg::NUM_WAYS-1:0]  tag_we,
  output cache_pkg::tag_entry_t           tag_wdata,
  input  cache_pkg::tag_entry_t           tag_rdata [cache_pkg::NUM_WAYS],
  output logic [cache_pkg::NUM_WAYS-1:0]  data_we,
  output cache_pkg::line_t                data_wdata,
  input  cache_pkg::line_t                data_rdata [cache_pkg::NUM_WAYS],
  // replacement
  output logic                            lru_touch,
  output logic [cache_pkg::WAY_BITS-1:0]  lru_way,
  input  logic [cache_pkg::WAY_BITS-1:0]  victim_way,
  // lower level
  output logic                            mem_req_valid,
  input  logic                            mem_req_ready,
  output cache_pkg::mem_req_t             mem_req,
  input  logic                            mem_resp_valid,
  input  cache_pkg::mem_resp_t            mem_resp
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, EVICT, FILL_REQ, FILL_WAIT, WRITE_LINE, RESPOND, FLUSH_SCAN
  } state_e;

  state_e     state_q, state_d;
  core_req_t  req_q;        // request under service
  addr_fields_t req_f;
  logic [WAY_BITS-1:0] way_q;  // hit way or victim
  line_t      line_q;       // fill line from memory
  core_resp_t resp_q;

  logic [NUM_WAYS-1:0] hit_vec;
  logic                hit_any;
  logic [WAY_BITS-1:0] hit_way;
  logic [1:0]          word_idx;               // word within the line
  logic                is_write;

  logic [SET_BITS+WAY_BITS-1:0] flush_idx_q;   // {set, way} scan position
  logic [SET_BITS-1:0] scan_set;
  logic [WAY_BITS-1:0] scan_way;
  logic                scan_dirty;
  logic                scan_step;

  function automatic word_t word_of(input line_t line, input logic [1:0] idx);
    return line[idx*WORD_BITS +: WORD_BITS];
  endfunction

  function automatic line_t merge_word(input line_t line, input logic [1:0] idx,
                                       input word_t wdata);
    line_t merged;
    merged = line;
    merged[idx*WORD_BITS +: WORD_BITS] = wdata;
    return merged;
  endfunction

  function automatic addr_t line_addr(input logic [TAG_BITS-1:0] tag,
                                      input logic [SET_BITS-1:0] set);
    return {tag, set, {OFFSET_BITS{1'b0}}};
  endfunction

  assign req_f    = addr_fields_t'(req_q.addr);
  assign word_idx = req_f.offset[OFFSET_BITS-1:2];  // low two bits dropped
  assign is_write = (req_q.op == OP_WRITE);
  assign {scan_set, scan_way} = flush_idx_q;
  assign scan_dirty = tag_rdata[scan_way].valid && tag_rdata[scan_way].dirty;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_f.tag);
      if (hit_vec[w]) hit_way = WAY_BITS'(w);
    end
    hit_any = |hit_vec;
  end

  assign req_ready  = (state_q == IDLE);
  assign resp_valid = (state_q == RESPOND);
  assign resp       = resp_q;

  always_comb begin
    state_d       = state_q;
    ram_set       = (state_q == FLUSH_SCAN) ? scan_set : req_f.set;
    tag_we        = '0;
    tag_wdata     = '0;            // zero entry is an invalidate
    data_we       = '0;
    data_wdata    = '0;
    lru_touch     = 1'b0;
    lru_way       = way_q;
    mem_req_valid = 1'b0;
    mem_req       = '0;
    scan_step     = 1'b0;
    case (state_q)
      IDLE: if (req_valid) state_d = (req.op == OP_FLUSH) ? FLUSH_SCAN : LOOKUP;
      LOOKUP: begin
        if (hit_any) begin
          lru_touch = 1'b1;
          lru_way   = hit_way;
          if (is_write) begin      // merge word, line goes dirty
            data_we[hit_way] = 1'b1;
            data_wdata       = merge_word(data_rdata[hit_way], word_idx, req_q.wdata);
            tag_we[hit_way]  = 1'b1;
            tag_wdata        = '{valid: 1'b1, dirty: 1'b1, tag: req_f.tag};
          end
          state_d = RESPOND;
        end else if (tag_rdata[victim_way].valid && tag_rdata[victim_way].dirty) begin
          state_d = EVICT;
        end else begin
          state_d = FILL_REQ;
        end
      end
      EVICT: begin                 // arrays untouched here, so payload holds
        mem_req_valid = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = line_addr(tag_rdata[way_q].tag, req_f.set);
        mem_req.wline = data_rdata[way_q];
        if (mem_req_ready) state_d = FILL_REQ;
      end
      FILL_REQ: begin
        mem_req_valid = 1'b1;
        mem_req.addr  = line_addr(req_f.tag, req_f.set);
        if (mem_req_ready) state_d = FILL_WAIT;
      end
      FILL_WAIT: if (mem_resp_valid) state_d = WRITE_LINE;
      WRITE_LINE: begin
        data_we[way_q] = 1'b1;
        data_wdata     = is_write ? merge_word(line_q, word_idx, req_q.wdata) : line_q;
        tag_we[way_q]  = 1'b1;
        tag_wdata      = '{valid: 1'b1, dirty: is_write, tag: req_f.tag};
        lru_touch      = 1'b1;     // lru_way already way_q
        state_d        = RESPOND;
      end
      RESPOND: if (resp_ready) state_d = IDLE;
      FLUSH_SCAN: begin
        if (scan_dirty) begin      // write back before the invalidate
          mem_req_valid = 1'b1;
          mem_req.we    = 1'b1;
          mem_req.addr  = line_addr(tag_rdata[scan_way].tag, scan_set);
          mem_req.wline = data_rdata[scan_way];
        end
        scan_step = !scan_dirty || mem_req_ready;
        if (scan_step) begin
          tag_we[scan_way] = 1'b1;
          if (&flush_idx_q) state_d = RESPOND;  // last set and way
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q     <= IDLE;
      flush_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (scan_step) flush_idx_q <= flush_idx_q + 1'b1;  // wraps back to zero
    end
  end

  always_ff @(posedge clk_in) begin
    case (state_q)
      IDLE: if (req_valid) req_q <= req;
      LOOKUP: begin
        way_q  <= hit_any ? hit_way : victim_way;
        resp_q <= '{rdata: (hit_any && req_q.op == OP_READ) ?
                           word_of(data_rdata[hit_way], word_idx) : '0,
                    hit: hit_any, op: req_q.op};
      end
      FILL_WAIT: if (mem_resp_valid) line_q <= mem_resp.rdata;
      WRITE_LINE: resp_q.rdata <= is_write ? '0 : word_of(line_q, word_idx);
      FLUSH_SCAN: resp_q <= '{rdata: '0, hit: 1'b0, op: OP_FLUSH};
      default: ;
    endcase
  end

  // tag store must never hold the same line twice in a set
  a_one_hit : assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    (state_q == LOOKUP) |-> $onehot0(hit_vec)
  );

  a_resp_hold : assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  );

endmodule

//--- rtl/backing_mem.sv
// 256-line memory, one access at a time, fixed MEM_LATENCY; reads answer once, writes are silent
module backing_mem (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  cache_pkg::mem_req_t   req,
  output logic                  resp_valid,  // one cycle, reads only
  output cache_pkg::mem_resp_t  resp
);
  import cache_pkg::*;

  line_t    mem [MEM_LINES];
  mem_req_t req_q;                     // access in progress
  logic     busy;
  logic [LAT_CNT_BITS-1:0] cnt;        // cycles left before the access
  logic [LINE_IDX_BITS-1:0] line_idx;
  logic     accept;
  logic     done;

  assign req_ready  = !busy;           // no second access while counting
  assign accept     = req_valid && req_ready;
  assign line_idx   = req_q.addr[ADDR_BITS-1:OFFSET_BITS];
  assign done       = busy && (cnt == '0);
  assign resp_valid = done && !req_q.we;
  assign resp.rdata = mem[line_idx];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      cnt  <= LAT_CNT_BITS'(MEM_LATENCY - 1);
    end else if (done) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) req_q <= req;
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int i = 0; i < MEM_LINES; i++) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          mem[i][w*WORD_BITS +: WORD_BITS] <= mem_init_word(word_addr_t'(i * WORDS_PER_LINE + w));
        end
      end
    end else if (done && req_q.we) begin
      mem[line_idx] <= req_q.wline;   // eviction lands at the end of the latency
    end
  end

  // a read answer comes exactly MEM_LATENCY cycles after its accept
  a_resp_timing : assert property (
    @(posedge clk_in) disable iff (!rst_N_in)
    resp_valid |-> $past(req_valid && req_ready && !req.we, MEM_LATENCY)
  );

endmodule

//--- rtl/cache_top.sv
// single-level cache over a simulated memory; core side handles one request at a time
module cache_top (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  cache_pkg::core_req_t   req,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output cache_pkg::core_resp_t  resp
);
  import cache_pkg::*;

  logic [SET_BITS-1:0] ram_set;
  logic [NUM_WAYS-1:0] tag_we, data_we;
  tag_entry_t          tag_wdata;
  tag_entry_t          tag_rdata [NUM_WAYS];
  line_t               data_wdata;
  line_t               data_rdata [NUM_WAYS];
  logic                lru_touch;
  logic [WAY_BITS-1:0] lru_way, victim_way;
  logic                mem_req_valid, mem_req_ready, mem_resp_valid;
  mem_req_t            mem_req;
  mem_resp_t           mem_resp;

  cache_ctrl cache_ctrl_i (.*);  // port names match the wires above

  set_ram #(.payload_t(tag_entry_t)) tag_ram (
    .clk_in, .rst_N_in, .set_idx(ram_set), .we(tag_we), .wdata(tag_wdata), .rdata(tag_rdata)
  );

  set_ram #(.payload_t(line_t)) data_ram (
    .clk_in, .rst_N_in, .set_idx(ram_set), .we(data_we), .wdata(data_wdata),
    .rdata(data_rdata)
  );

  plru_tree plru_tree_i (
    .clk_in, .rst_N_in, .set_idx(ram_set), .touch(lru_touch), .touch_way(lru_way),
    .victim_way
  );

  backing_mem backing_mem_i (
    .clk_in, .rst_N_in,
    .req_valid(mem_req_valid), .req_ready(mem_req_ready), .req(mem_req),
    .resp_valid(mem_resp_valid), .resp(mem_resp)
  );

endmodule

//--- test/cache_model.svh
// flat word model of the cache; tracks valid/tag and tree bits per set, fixed to 4 ways
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

word_t               ref_mem [2**(ADDR_BITS-2)];  // whole lower level, one entry per word
logic                ref_valid [NUM_SETS][NUM_WAYS];
logic [TAG_BITS-1:0] ref_tag [NUM_SETS][NUM_WAYS];
logic [2:0]          ref_lru [NUM_SETS];          // bit 0 root, 1 ways 0/1, 2 ways 2/3

function automatic void model_reset();
  for (int i = 0; i < 2**(ADDR_BITS-2); i++) begin
    ref_mem[i] = mem_init_word(word_addr_t'(i));
  end
  for (int s = 0; s < NUM_SETS; s++) begin
    ref_lru[s] = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      ref_valid[s][w] = 1'b0;
      ref_tag[s][w]   = '0;
    end
  end
endfunction

// walk from the root; a set bit means the right side is older
function automatic logic [1:0] victim_of(input logic [2:0] bits);
  if (bits[0]) begin
    return bits[2] ? 2'd3 : 2'd2;
  end
  return bits[1] ? 2'd1 : 2'd0;
endfunction

function automatic logic [2:0] touched(input logic [2:0] bits, input logic [1:0] way);
  logic [2:0] nb;
  nb = bits;
  if (way < 2'd2) begin
    nb[0] = 1'b1;            // root turns to the right pair
    nb[1] = (way == 2'd0);
  end else begin
    nb[0] = 1'b0;
    nb[2] = (way == 2'd2);
  end
  return nb;
endfunction

// expected response, updates the model as the cache would
function automatic core_resp_t expect_resp(input core_req_t r);
  logic [TAG_BITS-1:0]  tag;
  logic [SET_BITS-1:0]  set;
  logic [ADDR_BITS-3:0] widx;
  logic [1:0]           way;
  logic                 hit;
  core_resp_t           e;
  tag  = r.addr[ADDR_BITS-1 -: TAG_BITS];
  set  = r.addr[OFFSET_BITS +: SET_BITS];
  widx = r.addr[ADDR_BITS-1:2];
  e    = '0;
  e.op = r.op;
  if (r.op == OP_FLUSH) begin
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;  // tree bits survive a flush
      end
    end
    return e;
  end
  hit = 1'b0;
  way = victim_of(ref_lru[set]);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
      hit = 1'b1;
      way = 2'(w);
    end
  end
  ref_valid[set][way] = 1'b1;  // miss allocates the victim
  ref_tag[set][way]   = tag;
  ref_lru[set]        = touched(ref_lru[set], way);
  e.hit = hit;
  if (r.op == OP_WRITE) begin
    ref_mem[widx] = r.wdata;
  end else begin
    e.rdata = ref_mem[widx];
  end
  return e;
endfunction

task automatic check_resp(input core_resp_t got, input core_resp_t exp, input addr_t addr);
  if (got !== exp) begin
    $display("ERR %0t: %s at 0x%03h gave rdata %08h hit %0b op %0d, expected %08h hit %0b",
             $time, (exp.op == OP_WRITE) ? "write" : "read", addr, got.rdata, got.hit,
             got.op, exp.rdata, exp.hit);
    err_cnt++;
  end
endtask

task automatic check_flush(input core_resp_t got);
  if (got.op !== OP_FLUSH || got.hit !== 1'b0 || got.rdata !== '0) begin
    $display("ERR %0t: flush response op %0d hit %0b rdata %08h, expected op %0d, zeros",
             $time, got.op, got.hit, got.rdata, OP_FLUSH);
    err_cnt++;
  end
endtask

`endif

//--- test/cache_tb.sv
// drives cache_top with directed and random requests; expects the memory reset rule of cache_pkg
module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int CLK_NS        = 100;
  localparam int RAND_REQS     = 300;
  localparam int DIRECTED_REQS = 40;  // upper bound over tests 1 to 4
  localparam int CYCLE_BOUND   = 60;  // worst cycles per request

  logic       clk_in, rst_N_in;
  logic       req_valid, req_ready, resp_valid, resp_ready;
  core_req_t  req;
  core_resp_t resp;
  logic       bp_on;                  // random resp_ready drops
  int         err_cnt, n_req, n_resp, tests_run, tests_failed;
  core_resp_t exp_q [$];              // expected responses in request order
  addr_t      addr_q [$];

  `include "cache_model.svh"

  cache_top cache_top_i (.*);

  initial begin
    clk_in = 1'b0;
    forever #(CLK_NS / 2) clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    resp_ready <= bp_on ? ($urandom % 4 != 0) : 1'b1;  // about one cycle in four held off
  end

  task automatic issue_req(input cache_op_e req_op, input addr_t req_addr, input word_t req_wdata);
    core_req_t r;
    r = '{op: req_op, addr: req_addr, wdata: req_wdata};
    exp_q.push_back(expect_resp(r));
    addr_q.push_back(req_addr);
    n_req++;
    @(posedge clk_in);
    req_valid <= 1'b1;
    req       <= r;
    do @(negedge clk_in); while (!req_ready);  // taken at the next rising edge
    @(posedge clk_in);
    req_valid <= 1'b0;
  endtask

  task automatic drain_resps();
    while (exp_q.size() != 0) @(negedge clk_in);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // sampled mid-cycle, where valid and ready are settled
  always @(negedge clk_in) begin : compare_proc
    core_resp_t e;
    addr_t      a;
    if (rst_N_in && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        $display("extra response at %0t with no request outstanding", $time);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        a = addr_q.pop_front();
        if (e.op == OP_FLUSH) check_flush(resp);
        else check_resp(resp, e, a);
      end
      n_resp++;
    end
  end

  initial begin : watchdog
    #((DIRECTED_REQS + RAND_REQS) * CYCLE_BOUND * CLK_NS);
    $display("timeout: run did not finish, %0d responses outstanding", exp_q.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main_proc
    int errs;
    rst_N_in     = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    resp_ready   = 1'b0;
    bp_on        = 1'b0;
    err_cnt      = 0;
    n_req        = 0;
    n_resp       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'he3dc_49c5));
    model_reset();
    repeat (3) @(posedge clk_in);
    rst_N_in <= 1'b1;

    errs = err_cnt;  // cold misses, then hits in the same lines
    issue_req(OP_READ, 12'h000, '0);
    issue_req(OP_READ, 12'h004, '0);
    issue_req(OP_READ, 12'h3f0, '0);
    issue_req(OP_READ, 12'h3fc, '0);
    drain_resps();
    end_test("cold reads", errs);

    errs = err_cnt;
    issue_req(OP_WRITE, 12'h208, 32'hdead_beef);
    for (int o = 0; o < 16; o += 4) issue_req(OP_READ, addr_t'(12'h200 + o), '0);
    drain_resps();
    end_test("write then read", errs);

    errs = err_cnt;  // five lines fight for the four ways of set 1
    for (int t = 1; t <= 5; t++) issue_req(OP_WRITE, {6'(t), 2'b01, 4'h4}, 32'h5e70_0000 + t);
    for (int t = 1; t <= 5; t++) issue_req(OP_READ, {6'(t), 2'b01, 4'h4}, '0);
    drain_resps();
    end_test("eviction order", errs);

    errs = err_cnt;
    issue_req(OP_WRITE, 12'h040, 32'h0f1a_0001);
    issue_req(OP_WRITE, 12'h098, 32'h0f1a_0002);
    issue_req(OP_WRITE, 12'h0ec, 32'h0f1a_0003);
    issue_req(OP_FLUSH, 12'h000, '0);
    issue_req(OP_READ, 12'h040, '0);  // all of these miss after the flush
    issue_req(OP_READ, 12'h098, '0);
    issue_req(OP_READ, 12'h0ec, '0);
    issue_req(OP_READ, 12'h208, '0);
    drain_resps();
    end_test("flush write-back", errs);

    errs = err_cnt;
    bp_on = 1'b1;
    for (int i = 0; i < RAND_REQS; i++) begin
      issue_req(($urandom % 2 != 0) ? OP_WRITE : OP_READ, addr_t'(($urandom % 128) * 4), $urandom);
    end
    drain_resps();
    bp_on = 1'b0;
    end_test("random mix", errs);

    if (n_resp != n_req) begin
      $display("response count %0d does not match request count %0d", n_resp, n_req);
      err_cnt++;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+test
rtl/cache_pkg.sv
rtl/set_ram.sv
rtl/plru_tree.sv
rtl/cache_ctrl.sv
rtl/backing_mem.sv
rtl/cache_top.sv
test/cache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f vlog.f -o cache_tb_sim

status=0
./obj_dir/cache_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
